// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = core_tb
FLIST = vlog.f
PASS  = all tests passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

// File: source/bus_pkg.sv
package bus_pkg;

    localparam int mem_words       = 262144;
    localparam int imem_addr_width = 15;  // word addressed
    localparam int dmem_addr_width = 18;

    // x2 starts just past the last data word
    localparam logic [31:0] stack_top = 32'(mem_words * 4);

    localparam int out_credits  = 4;
    localparam int credit_width = $clog2(out_credits + 1);

    typedef logic [credit_width-1:0] credit_t;

    typedef struct packed {
        logic                       we;
        logic [dmem_addr_width-1:0] addr;  // word address
        logic [31:0]                wdata;
    } dmem_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } out_beat_t;

endpackage

// File: source/core_ctrl.sv
`timescale 1ns/1ps

module core_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cpu_pkg::xlen-1:0]            imem_data,
    output logic [bus_pkg::imem_addr_width-1:0] imem_addr,
    output logic [cpu_pkg::xlen-1:0]            inst,
    input  cpu_pkg::decoded_t                   dec,
    input  logic [cpu_pkg::xlen-1:0]            rs1_val,
    input  logic [cpu_pkg::xlen-1:0]            rs2_val,
    output cpu_pkg::decoded_t                   dec_q,
    output logic [cpu_pkg::xlen-1:0]            op_a,
    output logic [cpu_pkg::xlen-1:0]            op_b,
    output logic [cpu_pkg::xlen-1:0]            pc,
    input  cpu_pkg::exec_result_t               res,
    input  bus_pkg::dmem_req_t                  mem,
    input  logic [cpu_pkg::xlen-1:0]            dmem_rdata,
    output bus_pkg::dmem_req_t                  dmem_req,
    output logic                                rf_we,
    output logic [4:0]                          rf_idx,
    output logic [cpu_pkg::xlen-1:0]            rf_val,
    output bus_pkg::out_beat_t                  out_beat,
    input  logic                                out_credit,
    output logic                                halted
);

    logic                                stage_fetch;
    logic                                stage_read;
    logic                                stage_exec;
    logic                                stage_out;
    logic [1:0]                          exec_left;
    logic [bus_pkg::imem_addr_width-1:0] prev_addr;
    logic                                wb_pend;
    logic [4:0]                          wb_idx;
    logic [cpu_pkg::xlen-1:0]            wb_val;
    bus_pkg::credit_t                    credit_cnt;
    logic                                beat_fire;
    logic                                exec_done;

    assign beat_fire = stage_exec && res.is_out && credit_cnt != '0;
    // out waits on a credit while others count down
    assign exec_done = stage_exec && (res.is_out ? beat_fire : exec_left == 2'd1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage_fetch <= 1'b1;
            stage_read  <= 1'b0;
            stage_exec  <= 1'b0;
            stage_out   <= 1'b0;
            exec_left   <= 2'd0;
            pc          <= '0;
            imem_addr   <= '0;
            prev_addr   <= '0;
            wb_pend     <= 1'b0;
            halted      <= 1'b0;
        end else begin
            if (stage_fetch) begin
                stage_fetch <= 1'b0;
                stage_read  <= 1'b1;
            end
            if (stage_read) begin
                stage_read <= 1'b0;
                stage_exec <= 1'b1;
                exec_left  <= (dec.opcode == cpu_pkg::op_load) ? 2'd2 : 2'd1;
            end
            if (stage_exec) begin
                if (!res.is_out) begin
                    exec_left <= exec_left - 2'd1;
                end
                if (exec_done) begin
                    stage_exec <= 1'b0;
                    stage_out  <= 1'b1;
                    pc         <= res.next_pc;
                    imem_addr  <= res.next_pc[bus_pkg::imem_addr_width+1:2];
                    wb_pend    <= res.wb_en;
                end
            end
            if (stage_out) begin
                stage_out <= 1'b0;
                prev_addr <= imem_addr;
                if (imem_addr == prev_addr) begin
                    halted <= 1'b1;  // jump to self leaves every stage idle
                end else begin
                    stage_fetch <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit_cnt <= bus_pkg::credit_t'(bus_pkg::out_credits);
        end else if (beat_fire && !out_credit) begin
            credit_cnt <= credit_cnt - bus_pkg::credit_t'(1);
        end else if (out_credit && !beat_fire) begin
            credit_cnt <= credit_cnt + bus_pkg::credit_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (stage_fetch) begin
            inst <= imem_data;
        end
        if (stage_read) begin
            dec_q <= dec;
            op_a  <= rs1_val;
            op_b  <= rs2_val;
        end
        if (exec_done) begin
            wb_idx <= dec_q.rd;
            wb_val <= (dec_q.opcode == cpu_pkg::op_load) ? dmem_rdata : res.rd_value;
        end
    end

    assign rf_we  = stage_fetch && wb_pend;  // last instruction's result
    assign rf_idx = wb_idx;
    assign rf_val = wb_val;

    always_comb begin
        dmem_req    = mem;
        dmem_req.we = mem.we && stage_exec;  // stores finish execute in one cycle
    end

    always_comb begin
        out_beat.valid = beat_fire;
        out_beat.data  = op_a[7:0];
    end

    // the receiver never hands back more than it was given
    assert property (@(posedge clk) disable iff (!rst)
        credit_cnt <= bus_pkg::out_credits);
    assert property (@(posedge clk) rst && halted |=> halted);
    assert property (@(posedge clk) disable iff (!rst)
        halted |-> !dmem_req.we && !out_beat.valid);

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                                clk,
    input  logic                                rst,
    output logic [bus_pkg::imem_addr_width-1:0] imem_addr,
    input  logic [cpu_pkg::xlen-1:0]            imem_data,
    output bus_pkg::dmem_req_t                  dmem_req,
    input  logic [cpu_pkg::xlen-1:0]            dmem_rdata,
    output bus_pkg::out_beat_t                  out_beat,
    input  logic                                out_credit,
    output logic                                halted
);

    logic [cpu_pkg::xlen-1:0] inst;
    cpu_pkg::decoded_t        dec;
    cpu_pkg::decoded_t        dec_q;
    logic [cpu_pkg::xlen-1:0] rs1_val;
    logic [cpu_pkg::xlen-1:0] rs2_val;
    logic [cpu_pkg::xlen-1:0] op_a;
    logic [cpu_pkg::xlen-1:0] op_b;
    logic [cpu_pkg::xlen-1:0] pc;
    cpu_pkg::exec_result_t    res;
    bus_pkg::dmem_req_t       mem;
    logic                     rf_we;
    logic [4:0]               rf_idx;
    logic [cpu_pkg::xlen-1:0] rf_val;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (dec.rs1),
        .rs2_idx (dec.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (rf_we),
        .rd_idx  (rf_idx),
        .rd_val  (rf_val)
    );

    exec_unit u_exec (
        .dec     (dec_q),
        .rs1_val (op_a),
        .rs2_val (op_b),
        .pc      (pc),
        .res     (res),
        .mem     (mem)
    );

    core_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .inst       (inst),
        .dec        (dec),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .dec_q      (dec_q),
        .op_a       (op_a),
        .op_b       (op_b),
        .pc         (pc),
        .res        (res),
        .mem        (mem),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .rf_we      (rf_we),
        .rf_idx     (rf_idx),
        .rf_val     (rf_val),
        .out_beat   (out_beat),
        .out_credit (out_credit),
        .halted     (halted)
    );

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int sp_index  = 2;

    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_io     = 7'b1111111;

    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_slli = 3'b001;
    localparam logic [2:0] f3_xori = 3'b100;
    localparam logic [2:0] f3_srai = 3'b101;
    localparam logic [2:0] f3_andi = 3'b111;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sub = 3'b010;  // anything else on op is xor

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_beqi = 3'b010;  // compare against rs2 field
    localparam logic [2:0] f3_bnei = 3'b011;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_blti = 3'b110;
    localparam logic [2:0] f3_bgti = 3'b111;

    localparam logic [2:0] io_out = 3'b000;

    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;    // already sign extended for the format
        logic [4:0]      shamt;  // also the immediate branch operand
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] rd_value;
        logic            wb_en;
        logic [xlen-1:0] next_pc;
        logic            is_out;
    } exec_result_t;

endpackage

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  cpu_pkg::decoded_t        dec,
    input  logic [cpu_pkg::xlen-1:0] rs1_val,
    input  logic [cpu_pkg::xlen-1:0] rs2_val,
    input  logic [cpu_pkg::xlen-1:0] pc,
    output cpu_pkg::exec_result_t    res,
    output bus_pkg::dmem_req_t       mem
);

    logic [cpu_pkg::xlen-1:0] pc_plus4;
    logic [cpu_pkg::xlen-1:0] rs1_plus_imm;
    logic [cpu_pkg::xlen-1:0] cmp_imm;
    logic                     taken;

    assign pc_plus4     = pc + 32'd4;
    assign rs1_plus_imm = rs1_val + dec.imm;
    assign cmp_imm      = {27'd0, dec.shamt};

    always_comb begin
        case (dec.funct3)
            cpu_pkg::f3_beq:  taken = rs1_val == rs2_val;
            cpu_pkg::f3_bne:  taken = rs1_val != rs2_val;
            cpu_pkg::f3_blt:  taken = $signed(rs1_val) < $signed(rs2_val);
            cpu_pkg::f3_bge:  taken = $signed(rs1_val) >= $signed(rs2_val);
            cpu_pkg::f3_beqi: taken = rs1_val == cmp_imm;
            cpu_pkg::f3_bnei: taken = rs1_val != cmp_imm;
            cpu_pkg::f3_blti: taken = rs1_val < cmp_imm;  // unsigned
            cpu_pkg::f3_bgti: taken = rs1_val > cmp_imm;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        res.rd_value = '0;
        res.wb_en    = 1'b0;
        res.next_pc  = pc_plus4;
        res.is_out   = 1'b0;

        case (dec.opcode)
            cpu_pkg::op_imm: begin
                res.wb_en = 1'b1;
                case (dec.funct3)
                    cpu_pkg::f3_addi: res.rd_value = rs1_plus_imm;
                    cpu_pkg::f3_slli: res.rd_value = rs1_val << dec.shamt;
                    cpu_pkg::f3_xori: res.rd_value = rs1_val ^ dec.imm;
                    cpu_pkg::f3_srai: res.rd_value = $signed(rs1_val) >>> dec.shamt;
                    cpu_pkg::f3_andi: res.rd_value = rs1_val & dec.imm;
                    default:          res.rd_value = rs1_val;
                endcase
            end
            cpu_pkg::op_op: begin
                res.wb_en = 1'b1;
                case (dec.funct3)
                    cpu_pkg::f3_add: res.rd_value = rs1_val + rs2_val;
                    cpu_pkg::f3_sub: res.rd_value = rs1_val - rs2_val;
                    default:         res.rd_value = rs1_val ^ rs2_val;
                endcase
            end
            cpu_pkg::op_lui: begin
                res.wb_en    = 1'b1;
                res.rd_value = dec.imm;
            end
            cpu_pkg::op_auipc: begin
                res.wb_en    = 1'b1;
                res.rd_value = pc + dec.imm;
            end
            cpu_pkg::op_jalr: begin
                res.wb_en    = 1'b1;
                res.rd_value = pc_plus4;  // link
                res.next_pc  = rs1_plus_imm;
            end
            cpu_pkg::op_branch: begin
                res.next_pc = taken ? pc + dec.imm : pc_plus4;
            end
            cpu_pkg::op_load: begin
                res.wb_en = 1'b1;  // value comes from memory
            end
            cpu_pkg::op_io: begin
                res.is_out = dec.funct3 == cpu_pkg::io_out;
            end
            default: begin
                res.wb_en = 1'b0;
            end
        endcase
    end

    // same sum serves both load (I imm) and store (S imm)
    assign mem.we    = dec.opcode == cpu_pkg::op_store;
    assign mem.addr  = rs1_plus_imm[bus_pkg::dmem_addr_width+1:2];
    assign mem.wdata = rs2_val;

endmodule

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [cpu_pkg::xlen-1:0] inst,
    output cpu_pkg::decoded_t        dec
);

    logic [cpu_pkg::xlen-1:0] imm_i;
    logic [cpu_pkg::xlen-1:0] imm_s;
    logic [cpu_pkg::xlen-1:0] imm_b;
    logic [cpu_pkg::xlen-1:0] imm_u;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};

    always_comb begin
        dec.opcode = inst[6:0];
        dec.funct3 = inst[14:12];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.shamt  = inst[24:20];

        case (inst[6:0])
            cpu_pkg::op_imm,
            cpu_pkg::op_load,
            cpu_pkg::op_jalr: begin
                dec.imm = imm_i;
            end
            cpu_pkg::op_store: begin
                dec.imm = imm_s;
            end
            cpu_pkg::op_branch: begin
                dec.imm = imm_b;
            end
            cpu_pkg::op_lui,
            cpu_pkg::op_auipc: begin
                dec.imm = imm_u;
            end
            default: begin
                dec.imm = '0;  // op, io take no immediate
            end
        endcase
    end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4:0]               rs1_idx,
    input  logic [4:0]               rs2_idx,
    output logic [cpu_pkg::xlen-1:0] rs1_val,
    output logic [cpu_pkg::xlen-1:0] rs2_val,
    input  logic                     we,
    input  logic [4:0]               rd_idx,
    input  logic [cpu_pkg::xlen-1:0] rd_val
);

    logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= (i == cpu_pkg::sp_index) ? bus_pkg::stack_top : '0;
            end
        end else if (we && rd_idx != 5'd0) begin  // x0 never written
            regs[rd_idx] <= rd_val;
        end
    end

    assign rs1_val = regs[rs1_idx];
    assign rs2_val = regs[rs2_idx];

    // the controller must drop any pending write-back once reset is seen
    assert property (@(posedge clk) !rst |=> !we);

endmodule

// File: tests/core_ref.svh
// instruction-level model, one loop pass per instruction
function automatic int run_ref();
    logic [31:0] x [32];
    logic [31:0] pc, nxt, prev, ins, a, b, r, ea;
    logic [31:0] imm_i, imm_s, imm_b;
    logic [4:0]  sh;
    logic        wr;
    logic        tk;
    logic        stop;
    int          w;
    int          steps;

    foreach (x[i]) x[i] = '0;
    x[cpu_pkg::sp_index] = bus_pkg::stack_top;
    pc    = '0;
    prev  = '0;
    steps = 0;
    do begin
        ins   = prog[pc[9:2]];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        sh    = ins[24:20];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        nxt   = pc + 32'd4;
        r     = '0;
        wr    = 1'b1;
        steps++;
        case (ins[6:0])
            cpu_pkg::op_imm: begin
                case (ins[14:12])
                    cpu_pkg::f3_addi: r = a + imm_i;
                    cpu_pkg::f3_slli: r = a << sh;
                    cpu_pkg::f3_xori: r = a ^ imm_i;
                    cpu_pkg::f3_srai: r = $signed(a) >>> sh;
                    cpu_pkg::f3_andi: r = a & imm_i;
                    default:          r = a;
                endcase
            end
            cpu_pkg::op_op: begin
                case (ins[14:12])
                    cpu_pkg::f3_add: r = a + b;
                    cpu_pkg::f3_sub: r = a - b;
                    default:         r = a ^ b;
                endcase
            end
            cpu_pkg::op_lui:   r = {ins[31:12], 12'd0};
            cpu_pkg::op_auipc: r = pc + {ins[31:12], 12'd0};
            cpu_pkg::op_jalr: begin
                r   = pc + 32'd4;
                nxt = a + imm_i;
            end
            cpu_pkg::op_branch: begin
                wr = 1'b0;
                case (ins[14:12])
                    cpu_pkg::f3_beq:  tk = a == b;
                    cpu_pkg::f3_bne:  tk = a != b;
                    cpu_pkg::f3_blt:  tk = $signed(a) < $signed(b);
                    cpu_pkg::f3_bge:  tk = $signed(a) >= $signed(b);
                    cpu_pkg::f3_beqi: tk = a == 32'(sh);
                    cpu_pkg::f3_bnei: tk = a != 32'(sh);
                    cpu_pkg::f3_blti: tk = a < 32'(sh);
                    default:          tk = a > 32'(sh);
                endcase
                if (tk) nxt = pc + imm_b;
            end
            cpu_pkg::op_load: begin
                ea = a + imm_i;
                w  = int'(ea[bus_pkg::dmem_addr_width+1:2]);
                r  = ref_mem.exists(w) ? ref_mem[w] : fill_word(w);
            end
            cpu_pkg::op_store: begin
                wr = 1'b0;
                ea = a + imm_s;
                w  = int'(ea[bus_pkg::dmem_addr_width+1:2]);
                ref_mem[w] = b;
            end
            cpu_pkg::op_io: begin
                wr = 1'b0;
                if (ins[14:12] == cpu_pkg::io_out) exp_bytes.push_back(a[7:0]);
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = r;
        stop = nxt == prev;  // jump to self
        prev = nxt;
        pc   = nxt;
    end while (!stop && steps < 4000);
    return steps;
endfunction

// File: tests/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    logic                                clk;
    logic                                rst;
    logic [bus_pkg::imem_addr_width-1:0] imem_addr;
    logic [31:0]                         imem_data;
    bus_pkg::dmem_req_t                  dmem_req;
    logic [31:0]                         dmem_rdata;
    bus_pkg::out_beat_t                  out_beat;
    logic                                out_credit;
    logic                                halted;

    logic [31:0] prog [256];
    logic [31:0] dmem [int];  // written words only
    logic [31:0] ref_mem [int];
    logic [7:0]  exp_bytes [$];
    int          prog_len;
    int          cycle;
    int          errors;
    int          beats;
    int          stalls;
    int          outstanding;
    int          drain_at;
    int          ref_steps;
    logic        ref_ready;

    core_top DUT (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .out_beat   (out_beat),
        .out_credit (out_credit),
        .halted     (halted)
    );

    always #5 clk = ~clk;

    // unwritten words read back as a hash of the word address
    function automatic logic [31:0] fill_word(int addr);
        return 32'(addr) * 32'h9e37_79b1 + 32'h0bad_f00d;
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_type(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                          logic [4:0] rs2);
        return {7'd0, rs2, rs1, f3, rd, cpu_pkg::op_op};
    endfunction

    function automatic logic [31:0] s_type(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::op_store};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::op_branch};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] out_op(logic [4:0] rs1);
        return i_type(cpu_pkg::op_io, cpu_pkg::io_out, 5'd0, rs1, 12'd0);
    endfunction

    task automatic append(logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    `include "core_ref.svh"

    task automatic build_program();
        foreach (prog[i]) prog[i] = '0;
        prog_len = 0;
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_addi, 5'd1, 5'd0, 12'h05a));
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_slli, 5'd3, 5'd1, 12'd4));
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_xori, 5'd4, 5'd3, 12'hfff));
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_srai, 5'd5, 5'd4, 12'h402));
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_andi, 5'd6, 5'd5, 12'h7f3));
        append(r_type(cpu_pkg::f3_add, 5'd7, 5'd1, 5'd6));
        append(r_type(cpu_pkg::f3_sub, 5'd8, 5'd7, 5'd3));
        append(r_type(3'd4, 5'd9, 5'd8, 5'd1));  // xor
        append(u_type(cpu_pkg::op_lui, 5'd10, 20'h12345));
        append(u_type(cpu_pkg::op_auipc, 5'd11, 20'h00001));
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_addi, 5'd12, 5'd0, 12'h100));
        for (int r = 1; r <= 11; r++) begin
            append(s_type(5'd12, 5'(r), 12'(4 * r)));  // x2 lands at 0x108
            append(out_op(5'(r)));
        end
        append(i_type(cpu_pkg::op_load, 3'b010, 5'd13, 5'd12, 12'd40));
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_xori, 5'd13, 5'd13, 12'h0f0));
        append(s_type(5'd12, 5'd13, 12'd64));
        append(i_type(cpu_pkg::op_load, 3'b010, 5'd14, 5'd12, 12'h200));  // never written
        append(r_type(cpu_pkg::f3_add, 5'd14, 5'd14, 5'd13));
        append(s_type(5'd2, 5'd14, 12'hffc));  // last word below the stack top
        append(i_type(cpu_pkg::op_load, 3'b010, 5'd16, 5'd2, 12'hffc));
        append(out_op(5'd16));
        append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_addi, 5'd15, 5'd15, 12'd1));
        append(out_op(5'd15));
        append(b_type(cpu_pkg::f3_bnei, 5'd15, 5'd5, 13'h1ff8));  // loop until x15 is 5
        for (int k = 0; k < 2; k++) begin
            for (int f = 0; f < 8; f++) begin
                append(b_type(3'(f), 5'd15, (k == 0) ? 5'd5 : 5'd3, 13'd8));
                append(i_type(cpu_pkg::op_imm, cpu_pkg::f3_addi, 5'd20, 5'd20, 12'(1 << f)));
            end
            append(out_op(5'd20));
        end
        append(u_type(cpu_pkg::op_auipc, 5'd21, 20'd0));
        append(i_type(cpu_pkg::op_jalr, 3'd0, 5'd22, 5'd21, 12'd12));
        append(out_op(5'd1));  // skipped by the jump
        append(out_op(5'd22));
        for (int r = 1; r <= 16; r++) begin
            append(out_op(5'(r)));  // burst that outruns the credits
        end
        append(b_type(cpu_pkg::f3_beq, 5'd0, 5'd0, 13'd0));
    endtask

    always @(negedge clk) begin
        int w;
        w = int'(dmem_req.addr);
        imem_data <= prog[imem_addr[7:0]];
        if (dmem_req.we) begin
            dmem[w] = dmem_req.wdata;
        end
        dmem_rdata <= dmem.exists(w) ? dmem[w] : fill_word(w);
    end

    initial begin
        logic [7:0] want;
        void'($urandom(94));
        forever begin
            @(negedge clk);
            cycle++;
            if (!rst && halted) begin
                errors++;
                $display("halted is high during reset");
            end
            if (halted && (out_beat.valid || dmem_req.we)) begin
                errors++;
                $display("beat or memory write after halt at cycle %0d", cycle);
            end
            if (outstanding == bus_pkg::out_credits) stalls++;
            if (out_beat.valid) begin
                beats++;
                if (outstanding >= bus_pkg::out_credits) begin
                    errors++;
                    $display("beat sent with no credit left at cycle %0d", cycle);
                end
                if (exp_bytes.size() == 0) begin
                    errors++;
                    $display("unexpected extra beat with data %02h", out_beat.data);
                end else begin
                    want = exp_bytes.pop_front();
                    if (out_beat.data !== want) begin
                        errors++;
                        $display("mismatch out_beat.data: got %02h expected %02h",
                                 out_beat.data, want);
                    end
                end
                outstanding++;
            end
            // the receiver frees a slot only once it is full
            if (outstanding == bus_pkg::out_credits && drain_at < 0) begin
                drain_at = cycle + int'($urandom_range(6, 0));
            end
            if (drain_at >= 0 && drain_at <= cycle) begin
                drain_at = -1;
                out_credit <= 1'b1;
                outstanding--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b0;
        imem_data   = '0;
        dmem_rdata  = '0;
        out_credit  = 1'b0;
        cycle       = 0;
        errors      = 0;
        beats       = 0;
        stalls      = 0;
        outstanding = 0;
        drain_at    = -1;
        ref_ready   = 1'b0;
        build_program();
        ref_steps = run_ref();
        ref_ready = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        if (halted) begin
            errors++;
            $display("halted is high right after reset");
        end
        wait (halted);
        repeat (100) @(negedge clk);
        if (exp_bytes.size() != 0) begin
            errors++;
            $display("%0d expected bytes never arrived", exp_bytes.size());
        end
        if (stalls == 0) begin
            errors++;
            $display("credits never ran out so back-pressure was not exercised");
        end
        if (dmem.size() != ref_mem.size()) begin
            errors++;
            $display("wrong number of written words: %0d, model has %0d", dmem.size(),
                     ref_mem.size());
        end
        foreach (ref_mem[a]) begin
            if (!dmem.exists(a)) begin
                errors++;
                $display("word %05h was never written", a);
            end else if (dmem[a] !== ref_mem[a]) begin
                errors++;
                $display("mismatch dmem[%05h]: got %08h expected %08h", a, dmem[a], ref_mem[a]);
            end
        end
        $display("beats %0d, credit stall cycles %0d, errors %0d", beats, stalls, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (ref_ready);
        repeat (ref_steps * 40 + 2000) @(posedge clk);
        $display("timeout, core did not finish within %0d cycles", ref_steps * 40 + 2000);
        $display("tests failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tests
source/cpu_pkg.sv
source/bus_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/core_ctrl.sv
source/core_top.sv
tests/core_tb.sv
